/* logic/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// processor address and the fields it splits into
`define DCACHE_ADDR_W 32
`define DCACHE_TAG_W 20
`define DCACHE_INDEX_W 7
`define DCACHE_OFFSET_W 3

// words per line, also the beats of every burst
`define DCACHE_LINE_WORDS 8

// associativity, one lru bit per set covers two ways
`define DCACHE_WAYS 2

`endif

/* logic/dcache_pkg.sv */
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

   // controller states, miss handling runs from LOAD through WB_RESP
   typedef enum logic [2:0] {
      IDLE,
      LOAD,
      INSTALL,
      WB_ADDR,
      WB_DATA,
      WB_RESP
   } dcache_state_e;

   typedef logic [31:0]                   word_t;
   typedef logic [`DCACHE_TAG_W-1:0]      tag_t;
   typedef logic [`DCACHE_INDEX_W-1:0]    index_t;
   typedef logic [`DCACHE_OFFSET_W-1:0]   offset_t;

   // word 0 sits in the low bits
   typedef logic [`DCACHE_LINE_WORDS-1:0][31:0] line_t;

   typedef struct packed {
      tag_t    tag;
      index_t  index;
      offset_t offset;
      logic [`DCACHE_ADDR_W-`DCACHE_TAG_W-`DCACHE_INDEX_W-`DCACHE_OFFSET_W-1:0] byte_off;
   } dcache_addr_t;

endpackage

`default_nettype wire

/* logic/dcache_lookup_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

interface dcache_lookup_if;
   import dcache_pkg::*;

   // lookup results from the tag array
   logic hit;
   logic hit_way;
   logic victim_way;
   logic victim_dirty;
   tag_t victim_tag;

   // update strobes from the controller
   logic access;
   logic store;
   logic install;

   modport tag_side (
      output hit, hit_way, victim_way, victim_dirty, victim_tag,
      input  access, store, install
   );

   modport ctrl_side (
      input  hit, victim_dirty, victim_tag,
      output access, store, install
   );

   modport data_side (
      input  hit_way, victim_way, store, install
   );

endinterface

`default_nettype wire

/* logic/dcache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_array (
   input  logic                     clk,
   input  logic                     reset,
   input  dcache_pkg::dcache_addr_t i_addr,
   dcache_lookup_if.tag_side        lookup
);
   import dcache_pkg::*;

   localparam int SETS = 1 << `DCACHE_INDEX_W;

   tag_t                    tags  [`DCACHE_WAYS][SETS];
   logic [SETS-1:0]         valid [`DCACHE_WAYS];
   logic [SETS-1:0]         dirty [`DCACHE_WAYS];
   // per set, the way to evict next
   logic [SETS-1:0]         lru;
   logic [`DCACHE_WAYS-1:0] match;
   index_t                  idx;

   assign idx = i_addr.index;

   // both ways compared in parallel against the request tag
   always_comb begin
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
         match[w] = valid[w][idx] & (tags[w][idx] == i_addr.tag);
      end
   end

   assign lookup.hit     = |match;
   assign lookup.hit_way = match[1];

   // victim info is read before the install edge overwrites it
   assign lookup.victim_way   = lru[idx];
   assign lookup.victim_dirty = dirty[lookup.victim_way][idx];
   assign lookup.victim_tag   = tags[lookup.victim_way][idx];

   always_ff @(posedge clk) begin
      if (lookup.install) begin
         tags[lookup.victim_way][idx] <= i_addr.tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int w = 0; w < `DCACHE_WAYS; w++) begin
            valid[w] <= '0;
            dirty[w] <= '0;
         end
         lru <= '0;
      end else if (lookup.install) begin
         // freshly filled line is clean, evict the other way next
         valid[lookup.victim_way][idx] <= 1'b1;
         dirty[lookup.victim_way][idx] <= 1'b0;
         lru[idx]                      <= ~lru[idx];
      end else if (lookup.access) begin
         lru[idx] <= ~lookup.hit_way;
         if (lookup.store) begin
            dirty[lookup.hit_way][idx] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/dcache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_data_array (
   input  logic                     clk,
   input  dcache_pkg::dcache_addr_t i_addr,
   input  dcache_pkg::word_t        i_wdata,
   input  logic [3:0]               i_byte_en,
   input  dcache_pkg::line_t        i_fill_line,
   dcache_lookup_if.data_side       lookup,
   output dcache_pkg::word_t        o_rdata,
   output dcache_pkg::line_t        o_victim_line
);
   import dcache_pkg::*;

   localparam int WORD_AW = `DCACHE_INDEX_W + `DCACHE_OFFSET_W;
   localparam int DEPTH   = 1 << WORD_AW;

   // word storage per way, addressed by {index, offset}
   word_t              mem [`DCACHE_WAYS][DEPTH];
   logic [WORD_AW-1:0] word_addr;

   assign word_addr = {i_addr.index, i_addr.offset};

   // only meaningful when the tag array reports a hit
   assign o_rdata = mem[lookup.hit_way][word_addr];

   // whole victim line, handed to the line buffer on a dirty eviction
   always_comb begin
      for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
         o_victim_line[w] = mem[lookup.victim_way][{i_addr.index, offset_t'(w)}];
      end
   end

   always_ff @(posedge clk) begin
      if (lookup.install) begin
         for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            mem[lookup.victim_way][{i_addr.index, offset_t'(w)}] <= i_fill_line[w];
         end
      end else if (lookup.store) begin
         // byte lanes of the addressed word in the hit way
         for (int b = 0; b < 4; b++) begin
            if (i_byte_en[b]) begin
               mem[lookup.hit_way][word_addr][8*b +: 8] <= i_wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* logic/dcache_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_line_buffer (
   input  logic              clk,
   input  logic              reset,
   input  dcache_pkg::word_t i_rdata,
   input  logic              i_rvalid,
   input  logic              i_capture,
   input  dcache_pkg::line_t i_victim_line,
   input  logic              i_wbeat,
   output dcache_pkg::line_t o_line,
   output dcache_pkg::word_t o_wdata
);
   import dcache_pkg::*;

   line_t   line;
   offset_t rcnt;
   offset_t wcnt;

   // refill bursts always start at word 0 so the counter wraps back there
   always_ff @(posedge clk) begin
      if (reset) begin
         rcnt <= '0;
      end else if (i_rvalid) begin
         rcnt <= rcnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wcnt <= '0;
      end else if (i_capture) begin
         wcnt <= '0;
      end else if (i_wbeat) begin
         wcnt <= wcnt + 1'b1;
      end
   end

   // capture swaps the installed refill for the evicted line
   always_ff @(posedge clk) begin
      if (i_capture) begin
         line <= i_victim_line;
      end else if (i_rvalid) begin
         line[rcnt] <= i_rdata;
      end
   end

   assign o_line  = line;
   assign o_wdata = line[wcnt];

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      i_read,
   input  logic                      i_write,
   input  dcache_pkg::word_t         i_addr,
   input  logic                      i_arready,
   input  logic                      i_rlast,
   input  logic                      i_rvalid,
   input  logic                      i_awready,
   input  logic                      i_wready,
   input  logic                      i_bvalid,
   dcache_lookup_if.ctrl_side        lookup,
   output logic                      o_stall,
   output logic [`DCACHE_ADDR_W-1:0] o_araddr,
   output logic                      o_arvalid,
   output logic [`DCACHE_ADDR_W-1:0] o_awaddr,
   output logic                      o_awvalid,
   output logic                      o_wvalid,
   output logic                      o_wlast,
   output logic                      o_capture,
   output logic                      o_wbeat
);
   import dcache_pkg::*;

   // bits below the set index, zero in a line address
   localparam int LINE_LSB = `DCACHE_ADDR_W - `DCACHE_TAG_W - `DCACHE_INDEX_W;

   dcache_state_e state;
   dcache_addr_t  req_addr;
   offset_t       wcnt;
   logic          req;

   assign req_addr = i_addr;
   assign req      = i_read | i_write;

   assign lookup.access  = (state == IDLE) & req & lookup.hit;
   assign lookup.store   = lookup.access & i_write;
   assign lookup.install = (state == INSTALL);

   // held request retries once the controller is back in IDLE
   assign o_stall   = (state != IDLE) | (req & ~lookup.hit);
   assign o_capture = lookup.install & lookup.victim_dirty;
   assign o_wbeat   = o_wvalid & i_wready;

   always_ff @(posedge clk) begin
      if (state == IDLE && req && !lookup.hit) begin
         o_araddr <= {req_addr.tag, req_addr.index, {LINE_LSB{1'b0}}};
      end
      if (o_capture) begin
         o_awaddr <= {lookup.victim_tag, req_addr.index, {LINE_LSB{1'b0}}};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= IDLE;
         o_arvalid <= 1'b0;
         o_awvalid <= 1'b0;
         o_wvalid  <= 1'b0;
         o_wlast   <= 1'b0;
         wcnt      <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (req && !lookup.hit) begin
                  o_arvalid <= 1'b1;
                  state     <= LOAD;
               end
            end
            LOAD: begin
               if (o_arvalid && i_arready) begin
                  o_arvalid <= 1'b0;
               end
               if (i_rvalid && i_rlast) begin
                  state <= INSTALL;
               end
            end
            INSTALL: begin
               if (lookup.victim_dirty) begin
                  o_awvalid <= 1'b1;
                  state     <= WB_ADDR;
               end else begin
                  state <= IDLE;
               end
            end
            WB_ADDR: begin
               if (i_awready) begin
                  o_awvalid <= 1'b0;
                  o_wvalid  <= 1'b1;
                  wcnt      <= '0;
                  state     <= WB_DATA;
               end
            end
            WB_DATA: begin
               if (i_wready) begin
                  wcnt <= wcnt + 1'b1;
                  if (o_wlast) begin
                     o_wvalid <= 1'b0;
                     o_wlast  <= 1'b0;
                     state    <= WB_RESP;
                  end else if (wcnt == offset_t'(`DCACHE_LINE_WORDS - 2)) begin
                     // next beat is the last of the burst
                     o_wlast <= 1'b1;
                  end
               end
            end
            WB_RESP: begin
               if (i_bvalid) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      i_read,
   input  logic                      i_write,
   input  dcache_pkg::word_t         i_addr,
   input  dcache_pkg::word_t         i_wdata,
   input  logic [3:0]                i_byte_en,
   input  logic                      i_arready,
   input  dcache_pkg::word_t         i_rdata,
   input  logic                      i_rvalid,
   input  logic                      i_rlast,
   input  logic                      i_awready,
   input  logic                      i_wready,
   input  logic                      i_bvalid,
   output dcache_pkg::word_t         o_rdata,
   output logic                      o_stall,
   output logic [`DCACHE_ADDR_W-1:0] o_araddr,
   output logic                      o_arvalid,
   output logic [`DCACHE_ADDR_W-1:0] o_awaddr,
   output logic                      o_awvalid,
   output dcache_pkg::word_t         o_wdata,
   output logic                      o_wvalid,
   output logic                      o_wlast
);
   import dcache_pkg::*;

   line_t fill_line;
   line_t victim_line;
   logic  capture;
   logic  wbeat;

   dcache_lookup_if lookup ();

   dcache_tag_array u_tag_array (
      .clk    (clk),
      .reset  (reset),
      .i_addr (i_addr),
      .lookup (lookup.tag_side)
   );

   dcache_data_array u_data_array (
      .clk           (clk),
      .i_addr        (i_addr),
      .i_wdata       (i_wdata),
      .i_byte_en     (i_byte_en),
      .i_fill_line   (fill_line),
      .lookup        (lookup.data_side),
      .o_rdata       (o_rdata),
      .o_victim_line (victim_line)
   );

   dcache_line_buffer u_line_buffer (
      .clk           (clk),
      .reset         (reset),
      .i_rdata       (i_rdata),
      .i_rvalid      (i_rvalid),
      .i_capture     (capture),
      .i_victim_line (victim_line),
      .i_wbeat       (wbeat),
      .o_line        (fill_line),
      .o_wdata       (o_wdata)
   );

   dcache_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .i_read    (i_read),
      .i_write   (i_write),
      .i_addr    (i_addr),
      .i_arready (i_arready),
      .i_rlast   (i_rlast),
      .i_rvalid  (i_rvalid),
      .i_awready (i_awready),
      .i_wready  (i_wready),
      .i_bvalid  (i_bvalid),
      .lookup    (lookup.ctrl_side),
      .o_stall   (o_stall),
      .o_araddr  (o_araddr),
      .o_arvalid (o_arvalid),
      .o_awaddr  (o_awaddr),
      .o_awvalid (o_awvalid),
      .o_wvalid  (o_wvalid),
      .o_wlast   (o_wlast),
      .o_capture (capture),
      .o_wbeat   (wbeat)
   );

endmodule

`default_nettype wire

/* dv/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
   input  logic         clk,
   input  logic [31:0]  i_araddr,
   input  logic         i_arvalid,
   output logic         o_arready,
   output logic [31:0]  o_rdata,
   output logic         o_rvalid,
   output logic         o_rlast,
   input  logic [31:0]  i_awaddr,
   input  logic         i_awvalid,
   output logic         o_awready,
   input  logic [31:0]  i_wdata,
   input  logic         i_wvalid,
   input  logic         i_wlast,
   output logic         o_wready,
   output logic         o_bvalid,
   output logic [255:0] o_stored_line
);

   // sparse storage keyed by byte address, untouched words read the fill pattern
   logic [31:0] words [logic [31:0]];
   integer      rd_seed;
   integer      wr_seed;

   function automatic logic [31:0] init_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
   endfunction

   function automatic logic [31:0] read_word(input logic [31:0] addr);
      if (words.exists(addr)) begin
         return words[addr];
      end
      return init_word(addr);
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   initial begin : read_channel
      logic [31:0] r;
      logic [31:0] raddr;
      rd_seed   = 32'hf19b_5bc8;
      o_arready = 1'b0;
      o_rvalid  = 1'b0;
      o_rlast   = 1'b0;
      o_rdata   = '0;
      forever begin
         step();
         r = $random(rd_seed);
         o_arready = (r[1:0] != 2'b00);
         @(negedge clk);
         if (i_arvalid && o_arready) begin
            raddr = i_araddr;
            for (int b = 0; b < 8; b++) begin
               step();
               o_arready = 1'b0;
               r = $random(rd_seed);
               // idle cycles between beats
               while (r[2:0] == 3'b000) begin
                  o_rvalid = 1'b0;
                  o_rlast  = 1'b0;
                  step();
                  r = $random(rd_seed);
               end
               o_rvalid = 1'b1;
               o_rlast  = (b == 7);
               o_rdata  = read_word(raddr + 4 * b);
            end
            step();
            o_rvalid = 1'b0;
            o_rlast  = 1'b0;
         end
      end
   end

   initial begin : write_channel
      logic [31:0] r;
      logic [31:0] waddr;
      logic        last;
      int          beat;
      wr_seed       = 32'hf19b_5bc8;
      o_awready     = 1'b0;
      o_wready      = 1'b0;
      o_bvalid      = 1'b0;
      o_stored_line = '0;
      forever begin
         step();
         r = $random(wr_seed);
         o_awready = (r[1:0] != 2'b00);
         @(negedge clk);
         if (i_awvalid && o_awready) begin
            waddr = i_awaddr;
            beat  = 0;
            last  = 1'b0;
            step();
            o_awready = 1'b0;
            while (!last) begin
               r = $random(wr_seed);
               o_wready = (r[1:0] != 2'b00);
               @(negedge clk);
               if (i_wvalid && o_wready) begin
                  // an overlong burst wraps onto the same line
                  words[waddr + 4 * (beat % 8)] = i_wdata;
                  last = i_wlast;
                  beat++;
               end
               step();
            end
            o_wready = 1'b0;
            r = $random(wr_seed);
            repeat (r[1:0]) step();
            for (int k = 0; k < 8; k++) begin
               o_stored_line[32*k +: 32] = read_word(waddr + 4 * k);
            end
            o_bvalid = 1'b1;
            step();
            o_bvalid = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* dv/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

   localparam logic [19:0] TAG_BASE    = 20'h0a5c0;
   localparam logic [6:0]  SET_BASE    = 7'h10;
   localparam int          NUM_REQ     = 600;
   // each random request may be followed by a repeat, then the final readback
   localparam int          WATCHDOG_NS = (2 * NUM_REQ + 128) * 200 * 10;

   logic         clk;
   logic         reset;
   logic         cpu_read;
   logic         cpu_write;
   logic [31:0]  cpu_addr;
   logic [31:0]  cpu_wdata;
   logic [3:0]   cpu_byte_en;
   logic [31:0]  cpu_rdata;
   logic         stall;
   logic [31:0]  araddr;
   logic         arvalid;
   logic         arready;
   logic [31:0]  rdata;
   logic         rvalid;
   logic         rlast;
   logic [31:0]  awaddr;
   logic         awvalid;
   logic         awready;
   logic [31:0]  wdata;
   logic         wvalid;
   logic         wlast;
   logic         wready;
   logic         bvalid;
   logic [255:0] stored_line;
   // byte-wide reference memory, updated as each processor store completes
   logic [7:0]   ref_mem [logic [31:0]];
   integer       seed;
   int           errors;
   int           checks;

   dcache_top dut (
      .clk(clk), .reset(reset),
      .i_read(cpu_read), .i_write(cpu_write), .i_addr(cpu_addr),
      .i_wdata(cpu_wdata), .i_byte_en(cpu_byte_en),
      .i_arready(arready), .i_rdata(rdata), .i_rvalid(rvalid), .i_rlast(rlast),
      .i_awready(awready), .i_wready(wready), .i_bvalid(bvalid),
      .o_rdata(cpu_rdata), .o_stall(stall),
      .o_araddr(araddr), .o_arvalid(arvalid),
      .o_awaddr(awaddr), .o_awvalid(awvalid),
      .o_wdata(wdata), .o_wvalid(wvalid), .o_wlast(wlast)
   );

   axi_mem_model mem (
      .clk(clk),
      .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
      .o_rdata(rdata), .o_rvalid(rvalid), .o_rlast(rlast),
      .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
      .i_wdata(wdata), .i_wvalid(wvalid), .i_wlast(wlast), .o_wready(wready),
      .o_bvalid(bvalid), .o_stored_line(stored_line)
   );

   function automatic logic [31:0] init_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
   endfunction

   function automatic logic [31:0] make_addr(input logic [1:0] t, input logic [1:0] s,
                                             input logic [2:0] w);
      return {TAG_BASE + 20'(t), SET_BASE + 7'(s), w, 2'b00};
   endfunction

   function automatic logic in_range(input logic [31:0] addr);
      return (addr[31:12] >= TAG_BASE) && (addr[31:12] < TAG_BASE + 20'd4) &&
             (addr[11:5] >= SET_BASE) && (addr[11:5] < SET_BASE + 7'd4);
   endfunction

   function automatic logic [31:0] ref_word(input logic [31:0] addr);
      return {ref_mem[addr + 3], ref_mem[addr + 2], ref_mem[addr + 1], ref_mem[addr]};
   endfunction

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic init_reference();
      logic [31:0] a;
      logic [31:0] v;
      for (int i = 0; i < 128; i++) begin
         a = make_addr(2'(i >> 5), 2'(i >> 3), 3'(i));
         v = init_word(a);
         for (int b = 0; b < 4; b++) begin
            ref_mem[a + b] = v[8*b +: 8];
         end
      end
   endtask

   // entered 1 ns after a rising edge, returns 1 ns after the completing edge
   task automatic do_request(input logic is_write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] be,
                             input logic expect_hit);
      cpu_read    = ~is_write;
      cpu_write   = is_write;
      cpu_addr    = addr;
      cpu_wdata   = data;
      cpu_byte_en = be;
      @(negedge clk);
      if (expect_hit) begin
         check_value("o_stall", 32'h0, 32'(stall));
      end
      while (stall) begin
         @(negedge clk);
      end
      if (is_write) begin
         for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
               ref_mem[addr + b] = data[8*b +: 8];
            end
         end
      end else begin
         check_value("o_rdata", ref_word(addr), cpu_rdata);
      end
      @(posedge clk);
      #1;
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout after %0d ns, the cache stopped completing requests", WATCHDOG_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // burst shape and write-back contents, sampled mid-cycle
   initial begin : bus_monitor
      logic [31:0] wb_addr;
      int          wbeats;
      wb_addr = '0;
      wbeats  = 0;
      forever begin
         @(negedge clk);
         if (!reset && arvalid && arready) begin
            check_value("o_araddr low bits", 32'h0, 32'(araddr[4:0]));
            check_value("o_araddr in range", 32'h1, 32'(in_range(araddr)));
         end
         if (!reset && awvalid && awready) begin
            check_value("o_awaddr low bits", 32'h0, 32'(awaddr[4:0]));
            check_value("o_awaddr in range", 32'h1, 32'(in_range(awaddr)));
            wb_addr = awaddr;
            wbeats  = 0;
         end
         if (!reset && wvalid && wready) begin
            wbeats++;
            check_value("o_wlast", 32'(wbeats == 8), 32'(wlast));
         end
         if (!reset && bvalid) begin
            check_value("write burst beats", 32'd8, 32'(wbeats));
            for (int k = 0; k < 8; k++) begin
               check_value("written back word", ref_word(wb_addr + 4 * k),
                           stored_line[32*k +: 32]);
            end
         end
      end
   end

   initial begin
      logic [31:0] r;
      logic [31:0] addr;
      seed        = 32'hf19b_5bc8;
      errors      = 0;
      checks      = 0;
      reset       = 1'b1;
      cpu_read    = 1'b0;
      cpu_write   = 1'b0;
      cpu_addr    = '0;
      cpu_wdata   = '0;
      cpu_byte_en = '0;
      init_reference();
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_value("o_stall", 32'h0, 32'(stall));
      check_value("o_arvalid", 32'h0, 32'(arvalid));
      check_value("o_awvalid", 32'h0, 32'(awvalid));
      check_value("o_wvalid", 32'h0, 32'(wvalid));
      @(posedge clk);
      #1;
      for (int n = 0; n < NUM_REQ; n++) begin
         r    = next_rand();
         addr = make_addr(r[1:0], r[3:2], r[6:4]);
         do_request(r[7], addr, next_rand(), r[11:8], 1'b0);
         // the line just used must still be resident
         if (r[13:12] == 2'b00) begin
            do_request(1'b0, {addr[31:5], r[19:17], 2'b00}, 32'h0, 4'h0, 1'b1);
         end
         if (r[16:14] == 3'b000) begin
            cpu_read  = 1'b0;
            cpu_write = 1'b0;
            @(posedge clk);
            #1;
         end
      end
      for (int i = 0; i < 128; i++) begin
         do_request(1'b0, make_addr(2'(i >> 5), 2'(i >> 3), 3'(i)), 32'h0, 4'h0, 1'b0);
      end
      cpu_read  = 1'b0;
      cpu_write = 1'b0;
      repeat (2) @(posedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_lookup_if.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_line_buffer.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/axi_mem_model.sv
dv/dcache_tb.sv

/* run_verilator.sh */
#!/bin/sh
# build the dcache testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module dcache_tb \
   -f vlog.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
